//--- src/tile_pkg.sv
// Shared definitions of the compute tile bus
// Wishbone classic only: no rty, cab, cti or bte
// Address map: local memory 0x00000000-0x7fffffff, boot ROM 0xf0000000-0xffffffff
// Everything else on the bus answers with err
`default_nettype none

package tile_pkg;

   localparam int ADR_W = 32;
   localparam int DAT_W = 32;
   localparam int SEL_W = 4;                         // One enable per byte

   localparam int NR_MASTERS = 2;
   localparam int NR_SLAVES  = 2;
   localparam int SLAVE_LMEM = 0;
   localparam int SLAVE_BOOT = 1;

   localparam int LMEM_SIZE = 1024;                  // Bytes, window aliases modulo this
   localparam int LMEM_AW   = 8;                     // Word index width

   localparam int                      LMEM_MATCH_W = 1;
   localparam logic [LMEM_MATCH_W-1:0] LMEM_MATCH   = 1'b0;
   localparam int                      BOOT_MATCH_W = 4;
   localparam logic [BOOT_MATCH_W-1:0] BOOT_MATCH   = 4'hf;

   localparam int BOOT_WORDS = 16;                   // Index wraps modulo this

   typedef logic [DAT_W-1:0] boot_image_t [BOOT_WORDS];

   // Small startup loop, padded with nops
   localparam boot_image_t BOOT_IMAGE = '{
      32'h1800_0000, 32'ha800_0000, 32'h1820_0000, 32'ha821_0400,
      32'h1840_f000, 32'ha842_0040, 32'he060_0004, 32'hd401_1800,
      32'h8481_0000, 32'he084_1000, 32'h03ff_fffc, 32'h1500_0000,
      32'h4400_4800, 32'h1500_0000, 32'h1500_0000, 32'h1500_0000
   };

   typedef struct packed {
      logic [ADR_W-1:0] adr;
      logic [DAT_W-1:0] dat;
      logic [SEL_W-1:0] sel;
      logic             we;
      logic             cyc;
      logic             stb;
   } wb_req_t;

   typedef struct packed {
      logic [DAT_W-1:0] dat;
      logic             ack;
      logic             err;
   } wb_rsp_t;

   typedef logic [NR_SLAVES-1:0] slave_sel_t;        // One-hot, all zero if unmapped

endpackage

`default_nettype wire

//--- src/tile_arbiter.sv
// Round-robin bus ownership for the two tile masters
// Grant only moves while its owner holds cyc low, so a transfer
// is never cut off. A master without grant just waits.
// The round-robin step assumes exactly two masters
`timescale 1ns/1ns
`default_nettype none

module tile_arbiter
   import tile_pkg::*;
(
   input  wire                             clk,
   input  wire                             rst_i,
   input  wb_req_t [NR_MASTERS-1:0]        m_req_i,
   output wb_rsp_t [NR_MASTERS-1:0]        m_rsp_o,
   output wb_req_t                         bus_req_o,
   input  wb_rsp_t                         bus_rsp_i
);

   logic grant_q;                                    // Index of the owning master
   logic other;

   assign other = ~grant_q;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         grant_q <= 1'b0;
      end else if (!m_req_i[grant_q].cyc && m_req_i[other].cyc) begin
         grant_q <= other;                           // Owner idle, hand over
      end
   end

   // Owner's request goes straight onto the bus
   assign bus_req_o = m_req_i[grant_q];

   always_comb begin
      for (int m = 0; m < NR_MASTERS; m++) begin
         if (grant_q == 1'(m)) begin
            m_rsp_o[m] = bus_rsp_i;
         end else begin
            m_rsp_o[m] = '0;                         // Waiting master sees nothing
         end
      end
   end

endmodule

`default_nettype wire

//--- src/tile_addr_decoder.sv
// Address decoder between the arbiter and the tile slaves
// Only the matched slave sees cyc and stb; the others stay idle.
// Unmapped accesses get a registered err one cycle after stb
// The address must stay stable until ack or err, as the response
// mux follows the live address
`timescale 1ns/1ns
`default_nettype none

module tile_addr_decoder
   import tile_pkg::*;
(
   input  wire                             clk,
   input  wire                             rst_i,
   input  wb_req_t                         bus_req_i,
   output wb_rsp_t                         bus_rsp_o,
   output wb_req_t [NR_SLAVES-1:0]         slv_req_o,
   input  wb_rsp_t [NR_SLAVES-1:0]         slv_rsp_i
);

   slave_sel_t slv_sel;
   logic       unmapped;
   logic       err_q;

   always_comb begin
      slv_sel = '0;
      slv_sel[SLAVE_LMEM] = (bus_req_i.adr[ADR_W-1 -: LMEM_MATCH_W] == LMEM_MATCH);
      slv_sel[SLAVE_BOOT] = (bus_req_i.adr[ADR_W-1 -: BOOT_MATCH_W] == BOOT_MATCH);
   end

   assign unmapped = bus_req_i.cyc & bus_req_i.stb & ~|slv_sel;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= unmapped & ~err_q;                 // One pulse per transfer
      end
   end

   always_comb begin
      for (int s = 0; s < NR_SLAVES; s++) begin
         slv_req_o[s]     = bus_req_i;
         slv_req_o[s].cyc = bus_req_i.cyc & slv_sel[s];
         slv_req_o[s].stb = bus_req_i.stb & slv_sel[s];
      end
   end

   always_comb begin
      bus_rsp_o = '0;
      for (int s = 0; s < NR_SLAVES; s++) begin
         if (slv_sel[s]) begin
            bus_rsp_o = slv_rsp_i[s];
         end
      end
      bus_rsp_o.err = bus_rsp_o.err | err_q;         // Decoder's own error
   end

endmodule

`default_nettype wire

//--- src/tile_lmem.sv
// Local data memory slave, 256 words of 32 bits
// Byte enables apply on writes; the window aliases modulo 1024 bytes.
// Contents power up undefined, so software writes before it reads
// Answers every access with ack one cycle after stb, never err
`timescale 1ns/1ns
`default_nettype none

module tile_lmem
   import tile_pkg::*;
(
   input  wire         clk,
   input  wire         rst_i,
   input  wb_req_t     req_i,
   output wb_rsp_t     rsp_o
);

   logic [DAT_W-1:0]   mem_q [LMEM_SIZE/SEL_W];
   logic [LMEM_AW-1:0] word_idx;
   logic               access;
   logic               wr_en;
   logic               ack_q;
   logic [DAT_W-1:0]   rd_dat_q;

   assign word_idx = req_i.adr[LMEM_AW+1:2];         // Byte offset dropped
   assign access   = req_i.cyc & req_i.stb & ~ack_q;
   assign wr_en    = access & req_i.we;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int b = 0; b < SEL_W; b++) begin
            if (req_i.sel[b]) begin
               mem_q[word_idx][8*b +: 8] <= req_i.dat[8*b +: 8];
            end
         end
      end
      rd_dat_q <= mem_q[word_idx];                   // Valid alongside ack on reads
   end

   always_comb begin
      rsp_o.dat = rd_dat_q;
      rsp_o.ack = ack_q;
      rsp_o.err = 1'b0;
   end

endmodule

`default_nettype wire

//--- src/tile_bootrom.sv
// Boot ROM slave holding the fixed 16-word startup image
// Reads get ack with the word at address bits 5:2, wrapping over the window
// Writes get err and leave nothing changed
`timescale 1ns/1ns
`default_nettype none

module tile_bootrom
   import tile_pkg::*;
(
   input  wire         clk,
   input  wire         rst_i,
   input  wb_req_t     req_i,
   output wb_rsp_t     rsp_o
);

   logic [$clog2(BOOT_WORDS)-1:0] word_idx;
   logic                          access;
   logic                          ack_q;
   logic                          err_q;
   logic [DAT_W-1:0]              dat_q;

   assign word_idx = req_i.adr[$clog2(BOOT_WORDS)+1:2];
   assign access   = req_i.cyc & req_i.stb & ~(ack_q | err_q);

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= access & ~req_i.we;
         err_q <= access & req_i.we;                 // Read-only
      end
   end

   always_ff @(posedge clk) begin
      dat_q <= BOOT_IMAGE[word_idx];
   end

   always_comb begin
      rsp_o.dat = dat_q;
      rsp_o.ack = ack_q;
      rsp_o.err = err_q;
   end

endmodule

`default_nettype wire

//--- src/compute_tile_bus.sv
// Shared on-tile Wishbone classic bus of the compute tile
// Two master ports share the bus through a round-robin arbiter.
// The owning master gets its ack or err one cycle after stb;
// a master waiting for grant sees a longer, variable latency
// Slave 0 is local memory, slave 1 the boot ROM, the rest gets err
`timescale 1ns/1ns
`default_nettype none

module compute_tile_bus
   import tile_pkg::*;
(
   input  wire                             clk,
   input  wire                             rst_i,
   input  wb_req_t [NR_MASTERS-1:0]        m_req_i,
   output wb_rsp_t [NR_MASTERS-1:0]        m_rsp_o
);

   wb_req_t                  bus_req;                // Granted master's request
   wb_rsp_t                  bus_rsp;
   wb_req_t [NR_SLAVES-1:0]  slv_req;
   wb_rsp_t [NR_SLAVES-1:0]  slv_rsp;

   tile_arbiter u_arbiter (
      .clk       (clk),
      .rst_i     (rst_i),
      .m_req_i   (m_req_i),
      .m_rsp_o   (m_rsp_o),
      .bus_req_o (bus_req),
      .bus_rsp_i (bus_rsp)
   );

   tile_addr_decoder u_decoder (
      .clk       (clk),
      .rst_i     (rst_i),
      .bus_req_i (bus_req),
      .bus_rsp_o (bus_rsp),
      .slv_req_o (slv_req),
      .slv_rsp_i (slv_rsp)
   );

   tile_lmem u_lmem (
      .clk   (clk),
      .rst_i (rst_i),
      .req_i (slv_req[SLAVE_LMEM]),
      .rsp_o (slv_rsp[SLAVE_LMEM])
   );

   tile_bootrom u_bootrom (
      .clk   (clk),
      .rst_i (rst_i),
      .req_i (slv_req[SLAVE_BOOT]),
      .rsp_o (slv_rsp[SLAVE_BOOT])
   );

endmodule

`default_nettype wire

//--- tb/tile_bus_chk.sv
// Protocol assertions on the master ports of the compute tile bus
// Bound to compute_tile_bus; fail_cnt counts failed assertions
`timescale 1ns/1ns
`default_nettype none

module tile_bus_chk
   import tile_pkg::*;
(
   input wire                              clk,
   input wire                              rst_i,
   input wb_req_t [NR_MASTERS-1:0]         m_req_i,
   input wb_rsp_t [NR_MASTERS-1:0]         m_rsp_i
);

   logic [NR_MASTERS-1:0] ack_v;
   logic [NR_MASTERS-1:0] err_v;
   logic [NR_MASTERS-1:0] cyc_v;
   logic [NR_MASTERS-1:0] rsp_v;                     // Any response, per master
   int                    fail_cnt = 0;

   always_comb begin
      for (int m = 0; m < NR_MASTERS; m++) begin
         ack_v[m] = m_rsp_i[m].ack;
         err_v[m] = m_rsp_i[m].err;
         cyc_v[m] = m_req_i[m].cyc;
      end
   end

   assign rsp_v = ack_v | err_v;

   a_ack_err_excl: assert property (@(posedge clk) disable iff (rst_i) (ack_v & err_v) == '0)
      else begin
         $error("ack and err high together");
         fail_cnt = fail_cnt + 1;
      end

   a_single_pulse: assert property (@(posedge clk) disable iff (rst_i)
                                    rsp_v != '0 |=> (rsp_v & $past(rsp_v)) == '0)
      else begin
         $error("response held for two cycles");
         fail_cnt = fail_cnt + 1;
      end

   a_rsp_with_cyc: assert property (@(posedge clk) disable iff (rst_i) (rsp_v & ~cyc_v) == '0)
      else begin
         $error("response to a master with cyc low");
         fail_cnt = fail_cnt + 1;
      end

   a_quiet_reset: assert property (@(posedge clk) rst_i |=> rsp_v == '0)
      else begin
         $error("response while in reset");
         fail_cnt = fail_cnt + 1;
      end

endmodule

`default_nettype wire

//--- tb/tile_scoreboard.sv
// Scoreboard for the compute tile bus, sampling both master ports on the
// rising edge. Local memory is modelled per byte and aliased modulo 1024;
// bytes never written are not compared. Bus ownership is tracked by the
// round-robin rule to check the one cycle latency of the owning master
`timescale 1ns/1ns
`default_nettype none

module tile_scoreboard
   import tile_pkg::*;
(
   input  wire                             clk,
   input  wire                             rst_i,
   input  wb_req_t [NR_MASTERS-1:0]        m_req_i,
   input  wb_rsp_t [NR_MASTERS-1:0]        m_rsp_i,
   output int                              data_err_o,
   output int                              proto_err_o,
   output int                              done_cnt_o
);

   logic [7:0]            mem_model [LMEM_SIZE];
   logic                  mem_valid [LMEM_SIZE];
   int                    owned_cnt [NR_MASTERS];   // Cycles with stb while owning the bus
   int                    rival_done [NR_MASTERS];  // Other master's completions while waiting
   int                    owner;
   logic [NR_MASTERS-1:0] rsp_q;

   initial begin
      for (int i = 0; i < LMEM_SIZE; i++) begin
         mem_valid[i] = 1'b0;
      end
      data_err_o  = 0;
      proto_err_o = 0;
      done_cnt_o  = 0;
   end

   task automatic report_mismatch(input int m, input string what, input logic [31:0] adr,
                                  input logic [31:0] got, input logic [31:0] exp);
      $display("** Error at %0t ns: master %0d %s at 0x%08h, got 0x%08h, expected 0x%08h",
               $time, m, what, adr, got, exp);
      data_err_o++;
   endtask

   task automatic report_protocol(input int m, input string what);
      $display("** Error at %0t ns: master %0d %s", $time, m, what);
      proto_err_o++;
   endtask

   task automatic check_transfer(input int m);
      wb_req_t          req;
      wb_rsp_t          rsp;
      int               base;
      logic             exp_ack;
      logic [DAT_W-1:0] exp_dat;
      logic [DAT_W-1:0] mask;
      req     = m_req_i[m];
      rsp     = m_rsp_i[m];
      exp_dat = '0;
      mask    = '0;
      if (req.adr[31] == 1'b0) begin                     // Local memory window
         exp_ack = 1'b1;
         base    = int'(req.adr % LMEM_SIZE);
         for (int b = 0; b < SEL_W; b++) begin
            if (req.we && req.sel[b]) begin
               mem_model[base + b] = req.dat[8*b +: 8];
               mem_valid[base + b] = 1'b1;
            end else if (!req.we && mem_valid[base + b]) begin
               exp_dat[8*b +: 8] = mem_model[base + b];
               mask[8*b +: 8]    = 8'hff;
            end
         end
      end else if (req.adr[31:28] == 4'hf) begin         // Boot ROM, read-only
         exp_ack = !req.we;
         if (!req.we) begin
            exp_dat = BOOT_IMAGE[int'((req.adr / 4) % BOOT_WORDS)];
            mask    = '1;
         end
      end else begin
         exp_ack = 1'b0;                                 // Unmapped
      end
      if (rsp.ack !== exp_ack || rsp.err !== !exp_ack) begin
         report_mismatch(m, "ack/err", req.adr, {rsp.ack, rsp.err}, {exp_ack, !exp_ack});
      end else if (((rsp.dat ^ exp_dat) & mask) !== '0) begin
         report_mismatch(m, "read data", req.adr, rsp.dat, exp_dat);
      end
   endtask

   always @(posedge clk) begin
      if (rst_i) begin
         owner = 0;
         rsp_q = '0;
         for (int m = 0; m < NR_MASTERS; m++) begin
            owned_cnt[m]  = 0;
            rival_done[m] = 0;
         end
      end else begin
         for (int m = 0; m < NR_MASTERS; m++) begin
            if (!m_req_i[m].cyc) begin
               rival_done[m] = 0;
            end
            if (m_rsp_i[m].ack || m_rsp_i[m].err) begin
               if (rsp_q[m]) begin
                  report_protocol(m, "got a second response in a row");
               end else if (!(m_req_i[m].cyc && m_req_i[m].stb)) begin
                  report_protocol(m, "got a response without a request");
               end else begin
                  check_transfer(m);
                  done_cnt_o++;
                  if (owned_cnt[m] != 1) begin
                     report_protocol(m, $sformatf("answered after %0d cycles with grant",
                                                  owned_cnt[m]));
                  end
                  owned_cnt[m]  = 0;
                  rival_done[m] = 0;
                  if (m_req_i[1-m].cyc) begin
                     rival_done[1-m]++;
                     if (rival_done[1-m] > 1) begin
                        report_protocol(m, "finished twice while the other master waited");
                     end
                  end
               end
            end else if (m_req_i[m].cyc && m_req_i[m].stb && owner == m) begin
               owned_cnt[m]++;
            end
         end
         for (int m = 0; m < NR_MASTERS; m++) begin
            rsp_q[m] = m_rsp_i[m].ack | m_rsp_i[m].err;
         end
         if (!m_req_i[owner].cyc && m_req_i[1-owner].cyc) begin
            owner = 1 - owner;                           // Idle owner hands over
         end
      end
   end

endmodule

`default_nettype wire

//--- tb/tb_compute_tile.sv
// Testbench for the compute tile bus
// Fills local memory through master 0, then runs both masters with
// seeded random transfers and idle gaps. Reads of bytes that were never
// written are not compared. The scoreboard and the bound checker do the checking
`timescale 1ns/1ns
`default_nettype none

module tb_compute_tile
   import tile_pkg::*;
();

   localparam int          CLK_PERIOD = 40;
   localparam int          NR_XFERS   = 300;                 // Random transfers per master
   localparam int          NR_FILL    = LMEM_SIZE / SEL_W;   // One write per memory word
   localparam int          MAX_CYCLES = 40;                  // Generous bound per transfer
   localparam int          NR_TOTAL   = NR_FILL + NR_MASTERS * NR_XFERS;
   localparam int          TIMEOUT_NS = NR_TOTAL * MAX_CYCLES * CLK_PERIOD;
   localparam logic [31:0] SEED       = 32'h3f92_110b;

   logic                     clk;
   logic                     rst_i;
   wb_req_t [NR_MASTERS-1:0] m_req;
   wb_rsp_t [NR_MASTERS-1:0] m_rsp;
   int                       data_errs;
   int                       proto_errs;
   int                       done_cnt;

   compute_tile_bus dut (
      .clk     (clk),
      .rst_i   (rst_i),
      .m_req_i (m_req),
      .m_rsp_o (m_rsp)
   );

   tile_scoreboard u_scoreboard (
      .clk         (clk),
      .rst_i       (rst_i),
      .m_req_i     (m_req),
      .m_rsp_i     (m_rsp),
      .data_err_o  (data_errs),
      .proto_err_o (proto_errs),
      .done_cnt_o  (done_cnt)
   );

   bind compute_tile_bus tile_bus_chk u_bus_chk (
      .clk     (clk),
      .rst_i   (rst_i),
      .m_req_i (m_req_i),
      .m_rsp_i (m_rsp_o)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // One Wishbone classic transfer, released one cycle after ack or err
   task automatic do_transfer(input int m, input wb_req_t req);
      @(posedge clk);
      m_req[m] <= req;
      do begin
         @(posedge clk);
      end while (!(m_rsp[m].ack || m_rsp[m].err));
      m_req[m] <= '0;
   endtask

   function automatic wb_req_t random_request();
      wb_req_t     req;
      int unsigned pick;
      logic [31:0] r;
      pick = $urandom_range(99);
      r    = $urandom();
      req  = '0;
      if (pick < 60) begin
         req.adr = {1'b0, r[30:2], 2'b00};                  // Local memory
      end else if (pick < 85) begin
         req.adr = {4'hf, r[27:2], 2'b00};                  // Boot ROM
      end else begin
         req.adr = {4'(8 + $urandom_range(6)), r[27:2], 2'b00};  // Unmapped, 0x8 to 0xe
      end
      req.we  = 1'($urandom_range(1));
      req.dat = $urandom();
      req.sel = req.we ? 4'($urandom_range(15, 1)) : 4'hf;
      req.cyc = 1'b1;
      req.stb = 1'b1;
      return req;
   endfunction

   // Full word writes at random aliases of every memory word
   task automatic fill_memory();
      wb_req_t req;
      for (int w = 0; w < NR_FILL; w++) begin
         req     = '0;
         req.adr = {1'b0, 21'($urandom()), 10'(w * SEL_W)};
         req.dat = req.adr ^ {req.adr[15:0], req.adr[31:16]} ^ 32'h5a3c_96e1;
         req.sel = 4'hf;
         req.we  = 1'b1;
         req.cyc = 1'b1;
         req.stb = 1'b1;
         do_transfer(0, req);
      end
   endtask

   task automatic run_master(input int m);
      for (int i = 0; i < NR_XFERS; i++) begin
         do_transfer(m, random_request());
         repeat ($urandom_range(4)) @(posedge clk);        // Idle gap
      end
   endtask

   initial begin
      #(TIMEOUT_NS);
      $display("Watchdog expired after %0d ns, a transfer never got ack or err", TIMEOUT_NS);
      $display("Test failed");
      $finish;
   end

   initial begin
      int total_errs;
      m_req    = '0;
      rst_i    = 1'b1;
      void'($urandom(SEED));
      repeat (4) @(posedge clk);
      rst_i <= 1'b0;
      fill_memory();
      fork
         run_master(0);
         run_master(1);
      join
      repeat (4) @(posedge clk);
      total_errs = data_errs + proto_errs + dut.u_bus_chk.fail_cnt;
      if (done_cnt != NR_TOTAL) begin
         $display("Only %0d of %0d transfers were completed and checked", done_cnt, NR_TOTAL);
         total_errs = total_errs + 1;
      end
      $display("Transfers %0d, data errors %0d, protocol errors %0d, assertion failures %0d",
               done_cnt, data_errs, proto_errs, dut.u_bus_chk.fail_cnt);
      if (total_errs == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
src/tile_pkg.sv
src/tile_arbiter.sv
src/tile_addr_decoder.sv
src/tile_lmem.sv
src/tile_bootrom.sv
src/compute_tile_bus.sv
tb/tile_bus_chk.sv
tb/tile_scoreboard.sv
tb/tb_compute_tile.sv

//--- Bender.yml
package:
  name: compute_tile_bus

sources:
  # Package first, then the bus blocks, then the top level
  - src/tile_pkg.sv
  - src/tile_arbiter.sv
  - src/tile_addr_decoder.sv
  - src/tile_lmem.sv
  - src/tile_bootrom.sv
  - src/compute_tile_bus.sv

  - target: test
    files:
      - tb/tile_bus_chk.sv
      - tb/tile_scoreboard.sv
      - tb/tb_compute_tile.sv
